/* orbTop.f */
rtl/orbPkg.sv
rtl/linkPkg.sv
rtl/bufWriteIf.sv
rtl/uartRx.sv
rtl/uartTx.sv
rtl/orbPacker.sv
rtl/pingPongBuf.sv
rtl/frameReader.sv
rtl/orbTop.sv
tb/tbClock.sv
tb/orbTop_assert.sv
tb/orbTop_tb.sv

/* run.sh */
#!/bin/sh
# Verilator build and run of orbTop_tb, result taken from the log

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module orbTop_tb -f orbTop.f -o orbTop_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/orbTop_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^TEST PASS$" "$LOG"; then
	exit 0
fi
echo "pass line not found in $LOG"
exit 1

/* tb/orbTop_tb.sv */
`timescale 1ns/100ps

module orbTop_tb;
	import orbPkg::*;
	import linkPkg::*;

	localparam int NUM_CH = 2;
	localparam int BAUD_DIV = 16;
	localparam int BIT_DIV = 16;
	localparam int FRAME_WORDS = 8;
	localparam int WAIT_LIMIT = 2 * FRAME_WORDS * ORB_WORD_W * BIT_DIV;   // two frames
	localparam int LINE_BITS = BYTE_W + 4;   // start, data, stop, two idle bits

	logic clk100MHz;
	logic arstN;
	logic [NUM_CH-1:0] rx;
	logic [NUM_CH-1:0] tx;
	logic [NUM_CH-1:0] txEn;
	logic orbData;
	logic orbFrame;

	integer seed;
	logic [ORB_WORD_W-1:0] frameWords [FRAME_WORDS];   // last captured frame
	logic [ORB_WORD_W-1:0] expWords [FRAME_WORDS];

	tbClock uClk (.clk100MHz(clk100MHz));

	orbTop #(
		.NUM_CH(NUM_CH),
		.BAUD_DIV(BAUD_DIV),
		.BIT_DIV(BIT_DIV),
		.FRAME_WORDS(FRAME_WORDS)
	) u_orbTop (
		.clk100MHz(clk100MHz),
		.arstN(arstN),
		.rx(rx),
		.tx(tx),
		.txEn(txEn),
		.orbData(orbData),
		.orbFrame(orbFrame)
	);

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			failRun($sformatf("error %s: got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	function automatic logic [BYTE_W-1:0] randomByte();
		logic [31:0] r;
		r = $random(seed);
		return r[BYTE_W-1:0];
	endfunction

	function automatic logic serialBit(input logic [BYTE_W-1:0] value, input logic stopBit,
			input int idx);
		if (idx == 0)
			return 1'b0;                   // start bit
		else if (idx <= BYTE_W)
			return value[idx-1];           // LSB first
		else if (idx == BYTE_W + 1)
			return stopBit;
		else
			return 1'b1;                   // idle gap
	endfunction

	// drives one byte on every channel in the mask, all in step
	task automatic sendSerial(input logic [NUM_CH-1:0] chMask,
			input logic [NUM_CH-1:0][BYTE_W-1:0] data, input logic stopBit);
		@(posedge clk100MHz);
		#1;
		for (int i = 0; i < LINE_BITS; i++)
		begin
			for (int c = 0; c < NUM_CH; c++)
				if (chMask[c])
					rx[c] = serialBit(data[c], stopBit, i);
			repeat (BAUD_DIV) @(posedge clk100MHz);
			#1;
		end
	endtask

	task automatic sendOne(input int ch, input logic [BYTE_W-1:0] value, input logic stopBit);
		logic [NUM_CH-1:0] mask;
		logic [NUM_CH-1:0][BYTE_W-1:0] data;
		mask = '0;
		data = '0;
		mask[ch] = 1'b1;
		data[ch] = value;
		sendSerial(mask, data, stopBit);
	endtask

	// decodes the request burst on all tx lines together
	task automatic receiveBurst();
		int cnt;
		logic [BYTE_W-1:0] rxd [NUM_CH];
		cnt = 0;
		while (txEn !== '0)
		begin
			@(negedge clk100MHz);
			cnt++;
			if (cnt > WAIT_LIMIT)
				failRun("timeout waiting for txEn to go low");
		end
		cnt = 0;
		while (txEn !== '1)
		begin
			@(negedge clk100MHz);
			cnt++;
			if (cnt > WAIT_LIMIT)
				failRun("timeout waiting for a request burst on tx");
		end
		for (int k = 0; k < REQ_BYTES; k++)
		begin
			for (int j = 0; j < BYTE_W + 2; j++)
			begin
				repeat ((k == 0 && j == 0) ? BAUD_DIV / 2 : BAUD_DIV) @(negedge clk100MHz);
				for (int c = 0; c < NUM_CH; c++)
				begin
					checkEq($sformatf("txEn[%0d]", c), 32'(txEn[c]), 32'(1));
					if (j == 0)
						checkEq($sformatf("tx[%0d] start bit", c), 32'(tx[c]), 32'(0));
					else if (j <= BYTE_W)
						rxd[c][j-1] = tx[c];
					else
						checkEq($sformatf("tx[%0d] stop bit", c), 32'(tx[c]), 32'(1));
				end
			end
			for (int c = 0; c < NUM_CH; c++)
				checkEq($sformatf("tx[%0d] request byte %0d", c, k), 32'(rxd[c]),
					32'(8'(REQ_BASE + 16 * c + k)));
		end
		repeat (BAUD_DIV / 2) @(negedge clk100MHz);   // past the last stop bit
		checkEq("txEn after burst", 32'(txEn), 32'(0));
	endtask

	task automatic waitFrameStart();
		int cnt;
		cnt = 0;
		while (orbFrame !== 1'b0)   // let a running marker finish
		begin
			@(negedge clk100MHz);
			cnt++;
			if (cnt > WAIT_LIMIT)
				failRun("timeout waiting for orbFrame to go low");
		end
		cnt = 0;
		while (orbFrame !== 1'b1)
		begin
			@(negedge clk100MHz);
			cnt++;
			if (cnt > WAIT_LIMIT)
				failRun("timeout waiting for orbFrame");
		end
	endtask

	// samples every orbit bit in its middle
	task automatic captureFrame();
		logic [ORB_WORD_W-1:0] word;
		waitFrameStart();
		word = '0;
		for (int w = 0; w < FRAME_WORDS; w++)
		begin
			for (int b = 0; b < ORB_WORD_W; b++)
			begin
				repeat ((w == 0 && b == 0) ? BIT_DIV / 2 : BIT_DIV) @(negedge clk100MHz);
				word = {word[ORB_WORD_W-2:0], orbData};   // MSB first
				if (w == 0 && b < 2)
					checkEq($sformatf("orbFrame in bit %0d", b), 32'(orbFrame), 32'(b == 0));
			end
			frameWords[w] = word;
		end
	endtask

	task automatic compareFrame();
		for (int w = 0; w < FRAME_WORDS; w++)
			checkEq($sformatf("orbData word %0d", w), 32'(frameWords[w]), 32'(expWords[w]));
	endtask

	task automatic testResetIdle();
		checkEq("tx", 32'(tx), 32'({NUM_CH{1'b1}}));
		checkEq("txEn", 32'(txEn), 32'(0));
		checkEq("orbFrame", 32'(orbFrame), 32'(0));
		for (int w = 0; w < FRAME_WORDS; w++)
			expWords[w] = FILL_WORD;   // nothing written before the first frame
		captureFrame();
		compareFrame();
		$display("reset idle checked");
	endtask

	task automatic testPollRequest();
		repeat (2) receiveBurst();   // one burst per frame
		$display("poll request checked");
	endtask

	task automatic testPacking();
		logic [BYTE_W-1:0] value;
		int ch;
		waitFrameStart();
		for (int i = 0; i < FRAME_WORDS; i++)
			expWords[i] = FILL_WORD;
		for (int i = 0; i < 6; i++)
		begin
			ch = (i < 3) ? 0 : 1;   // three on channel 0, then three on channel 1
			value = randomByte();
			sendOne(ch, value, 1'b1);
			expWords[i] = {TAG_W'(ch), value};
		end
		captureFrame();
		compareFrame();
		$display("packing checked");
	endtask

	task automatic testOverflow();
		logic [BYTE_W-1:0] b0, b1;
		waitFrameStart();
		for (int i = 0; i < 5; i++)
		begin
			b0 = randomByte();
			b1 = randomByte();
			sendSerial(2'b11, {b1, b0}, 1'b1);   // same-cycle strobes, channel 0 first
			if (2 * i + 1 < FRAME_WORDS)
			begin
				expWords[2*i] = {TAG_W'(0), b0};
				expWords[2*i+1] = {TAG_W'(1), b1};
			end
		end
		captureFrame();
		compareFrame();
		$display("overflow checked");
	endtask

	task automatic testFramingError();
		logic [BYTE_W-1:0] first, bad, last;
		first = randomByte();
		bad = randomByte();
		last = randomByte();
		for (int i = 0; i < FRAME_WORDS; i++)
			expWords[i] = FILL_WORD;
		expWords[0] = {TAG_W'(0), first};
		expWords[1] = {TAG_W'(0), last};   // bad byte leaves no gap
		waitFrameStart();
		sendOne(0, first, 1'b1);
		sendOne(0, bad, 1'b0);
		sendOne(0, last, 1'b1);
		captureFrame();
		compareFrame();
		$display("framing error checked");
	endtask

	initial
	begin
		seed = 32'h675;
		arstN = 1'b0;
		rx = '1;   // idle lines
		repeat (3) @(posedge clk100MHz);
		#1;
		arstN = 1'b1;
		@(negedge clk100MHz);
		testResetIdle();
		testPollRequest();
		testPacking();
		testOverflow();
		testFramingError();
		$display("TEST PASS");
		$finish;
	end

endmodule

/* tb/orbTop_assert.sv */
`timescale 1ns/100ps

module orbTop_assert #(
	parameter int NUM_CH = 2,
	parameter int BIT_DIV = 16
) (
	input logic clk100MHz,
	input logic arstN,
	input logic [NUM_CH-1:0] tx,
	input logic [NUM_CH-1:0] txEn,
	input logic orbFrame
);

	localparam int CNT_W = $clog2(BIT_DIV + 1);

	logic [CNT_W-1:0] frameCnt;   // cycles the marker has been high

	always_ff @(posedge clk100MHz or negedge arstN)
	begin
		if (!arstN)
			frameCnt <= '0;
		else if (orbFrame)
			frameCnt <= frameCnt + 1'b1;
		else
			frameCnt <= '0;
	end

	frameNotTooLong: assert property (@(posedge clk100MHz) disable iff (!arstN)
		orbFrame |-> frameCnt < CNT_W'(BIT_DIV))
		else $error("orbFrame high for more than %0d cycles", BIT_DIV);

	frameFullBit: assert property (@(posedge clk100MHz) disable iff (!arstN)
		$fell(orbFrame) |-> frameCnt == CNT_W'(BIT_DIV))
		else $error("orbFrame dropped after %0d cycles", frameCnt);

	// line must idle high whenever the driver is off
	txIdleHigh: assert property (@(posedge clk100MHz) disable iff (!arstN)
		(~tx & ~txEn) == '0)
		else $error("tx low while txEn is low");

	txEnInReset: assert property (@(posedge clk100MHz) !arstN |-> txEn == '0)
		else $error("txEn high during reset");

endmodule

bind orbTop orbTop_assert #(.NUM_CH(NUM_CH), .BIT_DIV(BIT_DIV)) uAssert (
	.clk100MHz(clk100MHz),
	.arstN(arstN),
	.tx(tx),
	.txEn(txEn),
	.orbFrame(orbFrame)
);

/* tb/tbClock.sv */
`timescale 1ns/100ps

module tbClock (
	output logic clk100MHz
);

	initial
		clk100MHz = 1'b0;

	always #5 clk100MHz = ~clk100MHz;   // 10 ns period

endmodule

/* rtl/orbTop.sv */
`timescale 1ns/100ps

module orbTop #(
	parameter int NUM_CH = 2,
	parameter int BAUD_DIV = 16,
	parameter int BIT_DIV = 16,
	parameter int FRAME_WORDS = 8
) (
	input  logic clk100MHz,
	input  logic arstN,
	input  logic [NUM_CH-1:0] rx,
	output logic [NUM_CH-1:0] tx,
	output logic [NUM_CH-1:0] txEn,
	output logic orbData,
	output logic orbFrame
);
	import orbPkg::*;
	import linkPkg::*;

	localparam int ADDR_W = $clog2(FRAME_WORDS);

	logic [NUM_CH-1:0] rxValid;
	logic [NUM_CH-1:0][BYTE_W-1:0] rxData;
	logic swap;
	logic pollReq;
	logic rdEn;
	logic [ADDR_W-1:0] rdAddr;
	logic [ORB_WORD_W-1:0] rdData;

	bufWriteIf #(.ADDR_W(ADDR_W)) wrBus ();

	// one receiver and one request sender per LCB
	for (genvar i = 0; i < NUM_CH; i++)
	begin : gCh
		uartRx #(.BAUD_DIV(BAUD_DIV)) uRx (
			.clk100MHz(clk100MHz),
			.arstN(arstN),
			.rx(rx[i]),
			.rxValid(rxValid[i]),
			.rxData(rxData[i])
		);

		uartTx #(.BAUD_DIV(BAUD_DIV)) uTx (
			.clk100MHz(clk100MHz),
			.arstN(arstN),
			.chanId(TAG_W'(i)),       // tag doubles as request code
			.pollReq(pollReq),
			.tx(tx[i]),
			.txEn(txEn[i])
		);
	end

	orbPacker #(.NUM_CH(NUM_CH), .FRAME_WORDS(FRAME_WORDS)) uPacker (
		.clk100MHz(clk100MHz),
		.arstN(arstN),
		.rxValid(rxValid),
		.rxData(rxData),
		.swap(swap),
		.wr(wrBus.packer)
	);

	pingPongBuf #(.FRAME_WORDS(FRAME_WORDS)) uBuf (
		.clk100MHz(clk100MHz),
		.arstN(arstN),
		.wr(wrBus.buffer),
		.swap(swap),
		.rdEn(rdEn),
		.rdAddr(rdAddr),
		.rdData(rdData)
	);

	frameReader #(.BIT_DIV(BIT_DIV), .FRAME_WORDS(FRAME_WORDS)) uReader (
		.clk100MHz(clk100MHz),
		.arstN(arstN),
		.rdData(rdData),
		.rdEn(rdEn),
		.rdAddr(rdAddr),
		.orbData(orbData),
		.orbFrame(orbFrame),
		.swap(swap),
		.pollReq(pollReq)
	);

endmodule

/* rtl/frameReader.sv */
`timescale 1ns/100ps

module frameReader #(
	parameter int BIT_DIV = 16,
	parameter int FRAME_WORDS = 8
) (
	input  logic clk100MHz,
	input  logic arstN,
	input  logic [orbPkg::ORB_WORD_W-1:0] rdData,
	output logic rdEn,
	output logic [$clog2(FRAME_WORDS)-1:0] rdAddr,
	output logic orbData,
	output logic orbFrame,
	output logic swap,
	output logic pollReq
);
	import orbPkg::*;

	localparam int TMR_W = $clog2(BIT_DIV);
	localparam int ADDR_W = $clog2(FRAME_WORDS);
	localparam int IDX_W = $clog2(ORB_WORD_W);

	logic [TMR_W-1:0] bitTmr;
	logic [IDX_W-1:0] bitIdx;
	logic [ADDR_W-1:0] wordIdx;
	logic [ORB_WORD_W-1:0] shiftReg;
	logic bitEnd, wordEnd, frameEnd, loadSlot;

	// the counters run two cycles ahead of the line
	// so the read at tick 0 falls in the last output bit of the previous word
	assign bitEnd = bitTmr == TMR_W'(BIT_DIV - 1);
	assign wordEnd = bitEnd && bitIdx == IDX_W'(ORB_WORD_W - 1);
	assign frameEnd = wordEnd && wordIdx == ADDR_W'(FRAME_WORDS - 1);
	assign loadSlot = bitTmr == TMR_W'(1);      // rdData valid here

	assign rdEn = bitTmr == '0 && bitIdx == '0;
	assign rdAddr = wordIdx;
	assign swap = frameEnd;        // banks flip before word 0 is fetched
	assign pollReq = frameEnd;
	assign orbData = shiftReg[ORB_WORD_W-1];   // MSB first

	always_ff @(posedge clk100MHz or negedge arstN)
	begin
		if (!arstN)
		begin
			bitTmr <= '0;
			bitIdx <= '0;
			wordIdx <= '0;
		end
		else
		begin
			bitTmr <= bitEnd ? '0 : bitTmr + 1'b1;
			if (wordEnd)
			begin
				bitIdx <= '0;
				wordIdx <= frameEnd ? '0 : wordIdx + 1'b1;
			end
			else if (bitEnd)
				bitIdx <= bitIdx + 1'b1;
		end
	end

	always_ff @(posedge clk100MHz or negedge arstN)
	begin
		if (!arstN)
		begin
			shiftReg <= '0;
			orbFrame <= 1'b0;
		end
		else if (loadSlot)
		begin
			if (bitIdx == '0)
			begin
				shiftReg <= rdData;
				orbFrame <= wordIdx == '0;   // marks the first bit only
			end
			else
			begin
				shiftReg <= {shiftReg[ORB_WORD_W-2:0], 1'b0};
				orbFrame <= 1'b0;
			end
		end
	end

endmodule

/* rtl/pingPongBuf.sv */
`timescale 1ns/100ps

module pingPongBuf #(
	parameter int FRAME_WORDS = 8
) (
	input  logic clk100MHz,
	input  logic arstN,
	bufWriteIf.buffer wr,
	input  logic swap,
	input  logic rdEn,
	input  logic [$clog2(FRAME_WORDS)-1:0] rdAddr,
	output logic [orbPkg::ORB_WORD_W-1:0] rdData
);
	import orbPkg::*;

	localparam int ADDR_W = $clog2(FRAME_WORDS);
	localparam int CNT_W = ADDR_W + 1;       // counts up to a full frame

	logic [ORB_WORD_W-1:0] mem [2*FRAME_WORDS];   // bank bit on top of address
	logic [CNT_W-1:0] fillCnt [2];
	logic wrBank;
	logic rdBank;
	logic wrOk;

	assign rdBank = ~wrBank;
	assign wr.overflow = fillCnt[wrBank] == CNT_W'(FRAME_WORDS);
	assign wrOk = wr.wrEn & ~wr.overflow;

	always_ff @(posedge clk100MHz or negedge arstN)
	begin
		if (!arstN)
		begin
			wrBank <= 1'b0;
			fillCnt[0] <= '0;
			fillCnt[1] <= '0;
		end
		else
		begin
			if (wrOk)
				fillCnt[wrBank] <= fillCnt[wrBank] + 1'b1;
			if (swap)
			begin
				wrBank <= ~wrBank;
				fillCnt[rdBank] <= '0;   // old read bank becomes the empty write bank
			end
		end
	end

	always_ff @(posedge clk100MHz)
	begin
		if (wrOk)
			mem[{wrBank, wr.wrAddr}] <= wr.wrData;
		if (rdEn)
			rdData <= (CNT_W'(rdAddr) < fillCnt[rdBank]) ? mem[{rdBank, rdAddr}] : FILL_WORD;
	end

endmodule

/* rtl/orbPacker.sv */
`timescale 1ns/100ps

module orbPacker #(
	parameter int NUM_CH = 2,
	parameter int FRAME_WORDS = 8
) (
	input  logic clk100MHz,
	input  logic arstN,
	input  logic [NUM_CH-1:0] rxValid,
	input  logic [NUM_CH-1:0][linkPkg::BYTE_W-1:0] rxData,
	input  logic swap,
	bufWriteIf.packer wr
);
	import orbPkg::*;
	import linkPkg::*;

	localparam int ADDR_W = $clog2(FRAME_WORDS);
	localparam int CH_W = (NUM_CH > 1) ? $clog2(NUM_CH) : 1;

	logic firstHit, secondHit;
	logic [CH_W-1:0] firstCh, secondCh;
	logic [ORB_WORD_W-1:0] firstWord, secondWord;
	logic pendValid, holdValid;
	logic [ORB_WORD_W-1:0] pendWord, holdWord;
	logic [ADDR_W-1:0] wrAddr;

	// lowest channel wins, the runner-up goes to the hold register
	always_comb
	begin
		firstHit = 1'b0;
		secondHit = 1'b0;
		firstCh = '0;
		secondCh = '0;
		for (int c = 0; c < NUM_CH; c++)
		begin
			if (rxValid[c] && !firstHit)
			begin
				firstHit = 1'b1;
				firstCh = CH_W'(c);
			end
			else if (rxValid[c] && !secondHit)
			begin
				secondHit = 1'b1;
				secondCh = CH_W'(c);
			end
		end
	end

	assign firstWord = {TAG_W'(firstCh), rxData[firstCh]};
	assign secondWord = {TAG_W'(secondCh), rxData[secondCh]};

	assign wr.wrEn = pendValid & ~wr.overflow;   // full bank drops the byte
	assign wr.wrAddr = wrAddr;
	assign wr.wrData = pendWord;

	always_ff @(posedge clk100MHz or negedge arstN)
	begin
		if (!arstN)
		begin
			pendValid <= 1'b0;
			holdValid <= 1'b0;
			wrAddr <= '0;
		end
		else
		begin
			if (holdValid)
			begin
				pendValid <= 1'b1;          // held byte is older, goes first
				holdValid <= firstHit;
			end
			else
			begin
				pendValid <= firstHit;
				holdValid <= secondHit;
			end
			if (swap)
				wrAddr <= '0;              // new bank starts at slot 0
			else if (wr.wrEn)
				wrAddr <= wrAddr + 1'b1;
		end
	end

	always_ff @(posedge clk100MHz)
	begin
		pendWord <= holdValid ? holdWord : firstWord;
		holdWord <= holdValid ? firstWord : secondWord;
	end

endmodule

/* rtl/uartTx.sv */
`timescale 1ns/100ps

module uartTx #(
	parameter int BAUD_DIV = 16
) (
	input  logic clk100MHz,
	input  logic arstN,
	input  logic [orbPkg::TAG_W-1:0] chanId,
	input  logic pollReq,
	output logic tx,
	output logic txEn
);
	import linkPkg::*;

	localparam int CNT_W = $clog2(BAUD_DIV);
	localparam int FRAME_BITS = BYTE_W + 2;          // start, data, stop
	localparam int BITS_W = $clog2(FRAME_BITS);
	localparam int BYTE_CNT_W = $clog2(REQ_BYTES + 1);

	logic [CNT_W-1:0] baudCnt;
	logic [BITS_W-1:0] bitCnt;
	logic [BYTE_CNT_W-1:0] byteCnt;    // index of the next byte to load
	logic [FRAME_BITS-1:0] txShift;
	logic [BYTE_W-1:0] reqByte;
	logic baudTick;

	assign reqByte = REQ_BASE + BYTE_W'(chanId) * BYTE_W'(REQ_CH_STEP) + BYTE_W'(byteCnt);
	assign baudTick = baudCnt == CNT_W'(BAUD_DIV - 1);
	assign tx = txShift[0];

	always_ff @(posedge clk100MHz or negedge arstN)
	begin
		if (!arstN)
		begin
			txShift <= '1;           // line idles high
			txEn <= 1'b0;
			baudCnt <= '0;
			bitCnt <= '0;
			byteCnt <= '0;
		end
		else if (!txEn)
		begin
			baudCnt <= '0;
			bitCnt <= '0;
			if (pollReq)
			begin
				txShift <= {1'b1, reqByte, 1'b0};
				byteCnt <= byteCnt + 1'b1;
				txEn <= 1'b1;        // driver on with the first start bit
			end
		end
		else if (baudTick)
		begin
			baudCnt <= '0;
			if (bitCnt == BITS_W'(FRAME_BITS - 1))
			begin
				bitCnt <= '0;
				if (byteCnt == BYTE_CNT_W'(REQ_BYTES))
				begin
					txEn <= 1'b0;    // burst done, release the bus
					byteCnt <= '0;
					txShift <= '1;
				end
				else
				begin
					txShift <= {1'b1, reqByte, 1'b0};   // next byte straight after stop
					byteCnt <= byteCnt + 1'b1;
				end
			end
			else
			begin
				bitCnt <= bitCnt + 1'b1;
				txShift <= {1'b1, txShift[FRAME_BITS-1:1]};
			end
		end
		else
			baudCnt <= baudCnt + 1'b1;
	end

endmodule

/* rtl/uartRx.sv */
`timescale 1ns/100ps

module uartRx #(
	parameter int BAUD_DIV = 16
) (
	input  logic clk100MHz,
	input  logic arstN,
	input  logic rx,
	output logic rxValid,
	output logic [linkPkg::BYTE_W-1:0] rxData
);
	import linkPkg::*;

	typedef enum logic [1:0] {IDLE, START, DATA, STOP} rxStateT;

	localparam int CNT_W = $clog2(BAUD_DIV);
	localparam int BIT_W = $clog2(BYTE_W);
	localparam int HALF = BAUD_DIV / 2 - 1;   // middle of the start bit

	rxStateT state;
	logic [2:0] rxSync;          // two sync flops plus previous value
	logic [CNT_W-1:0] baudCnt;
	logic [BIT_W-1:0] bitCnt;
	logic startEdge;
	logic baudTick;

	assign startEdge = rxSync[2] & ~rxSync[1];   // falling edge of synced line
	assign baudTick = baudCnt == CNT_W'(BAUD_DIV - 1);

	always_ff @(posedge clk100MHz or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= IDLE;
			rxSync <= '1;            // idle line is high
			baudCnt <= '0;
			bitCnt <= '0;
			rxValid <= 1'b0;
		end
		else
		begin
			rxSync <= {rxSync[1:0], rx};
			rxValid <= 1'b0;
			baudCnt <= baudTick ? '0 : baudCnt + 1'b1;
			case (state)
				IDLE:
					if (startEdge)
					begin
						state <= START;
						baudCnt <= '0;
					end
				START:
					if (baudCnt == CNT_W'(HALF))
					begin
						baudCnt <= '0;           // next ticks land mid-bit
						bitCnt <= '0;
						state <= rxSync[1] ? IDLE : DATA;   // glitch, not a start bit
					end
				DATA:
					if (baudTick)
					begin
						bitCnt <= bitCnt + 1'b1;
						if (bitCnt == BIT_W'(BYTE_W - 1))
							state <= STOP;
					end
				STOP:
					if (baudTick)
					begin
						state <= IDLE;
						rxValid <= rxSync[1];    // low stop bit means framing error
					end
				default: state <= IDLE;
			endcase
		end
	end

	// LSB arrives first
	always_ff @(posedge clk100MHz)
	begin
		if (state == DATA && baudTick)
			rxData <= {rxSync[1], rxData[BYTE_W-1:1]};
	end

endmodule

/* rtl/bufWriteIf.sv */
`timescale 1ns/100ps

interface bufWriteIf #(
	parameter int ADDR_W = 3
);
	import orbPkg::*;

	logic wrEn;                      // one write per high cycle
	logic [ADDR_W-1:0] wrAddr;       // slot in the write bank
	logic [ORB_WORD_W-1:0] wrData;   // tag plus byte
	logic overflow;                  // write bank holds a full frame

	modport packer (output wrEn, wrAddr, wrData, input overflow);
	modport buffer (input wrEn, wrAddr, wrData, output overflow);

endinterface

/* rtl/linkPkg.sv */
package linkPkg;

	// RS-485 link to the local control blocks, 8N1 framing
	localparam int BYTE_W = 8;               // data bits per serial byte

	// request burst sent to every LCB once per frame
	// byte k for channel c is REQ_BASE + 16*c + k
	localparam logic [BYTE_W-1:0] REQ_BASE = 8'hA0;   // first byte of channel 0
	localparam int REQ_BYTES = 2;            // bytes per burst
	localparam int REQ_CH_STEP = 16;         // spacing between channel codes

endpackage

/* rtl/orbPkg.sv */
package orbPkg;

	// orbit word layout
	// bits [11:8] hold the channel tag and bits [7:0] the received byte
	localparam int ORB_WORD_W = 12;       // bits per orbit word
	localparam int TAG_W = 4;             // channel tag in the upper bits

	// empty slot marker
	// never produced by a real channel since tag 4'hF is not used
	localparam logic [ORB_WORD_W-1:0] FILL_WORD = '1;

	// word bit positions
	localparam int TAG_LSB = ORB_WORD_W - TAG_W;   // first tag bit
	localparam int TAG_MSB = ORB_WORD_W - 1;       // top tag bit, also first bit on the line

	// tag plus byte must fill the word exactly
	// the packer relies on this when it concatenates the two
	localparam int PAYLOAD_W = ORB_WORD_W - TAG_W;  // bits left for data

endpackage
